//--- cpuPkg.sv
// subset MIPS types; no delay slots, so jal links pc+4 and MMIO sits at 0x4000_0000.
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;

    typedef enum logic [2:0] {
        OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT, OP_SLL, OP_LUI
    } aluOpT;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSelT;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} dstSelT;
    typedef enum logic [1:0] {FWD_REG, FWD_EXMEM, FWD_MEMWB} fwdSelT;

    typedef struct packed {
        logic regWr;
        logic memRd;
        logic memWr;
        logic branch;
        logic branchNe;
        logic jump;
        logic link;
        logic aluSrcImm;
        logic aluSrcShamt;
        logic signExt;
        aluOpT aluOp;
        wbSelT wbSel;
        dstSelT dstSel;
    } ctrlT;

    // an all-zero pipeline register is a bubble.
    typedef struct packed {
        logic valid;
        wordT pcPlus4;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT ctrl;
        wordT pcPlus4;
        wordT rsVal;
        wordT rtVal;
        wordT imm;
        regAddrT dst;
    } idExT;

    typedef struct packed {
        ctrlT ctrl;
        wordT result;
        wordT storeData;
        regAddrT dst;
    } exMemT;

    typedef struct packed {
        ctrlT ctrl;
        regAddrT dst;
        wordT result;
        wordT memData;
    } memWbT;

    localparam wordT LED_ADDR = 32'h4000_0000;
    localparam wordT DIGIT_ADDR = 32'h4000_0004;

endpackage

//--- instMem.sv
// word addressed, no reset; load port writes are only safe while the core is held.
`timescale 1ns/1ns

module instMem import cpuPkg::*; #(
    parameter int IMEM_AW = 8
) (
    input logic sysclk,
    input logic we,
    input logic [IMEM_AW-1:0] wrAddr,
    input wordT wrData,
    input logic [IMEM_AW-1:0] rdAddr,
    output wordT rdData
);

    wordT mem [2**IMEM_AW];

    always_ff @(posedge sysclk) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
    end

    // fetch sees the word in the same cycle.
    assign rdData = mem[rdAddr];

endmodule

//--- controlDecoder.sv
// decodes only the listed subset; anything else comes out as a bubble.
`timescale 1ns/1ns

module controlDecoder import cpuPkg::*; (
    input wordT instr,
    output ctrlT ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            6'h00: begin
                ctrl.regWr = 1'b1;
                ctrl.dstSel = DST_RD;
                case (funct)
                    6'h21: ctrl.aluOp = OP_ADDU;
                    6'h23: ctrl.aluOp = OP_SUBU;
                    6'h24: ctrl.aluOp = OP_AND;
                    6'h25: ctrl.aluOp = OP_OR;
                    6'h2a: ctrl.aluOp = OP_SLT;
                    6'h00: begin
                        ctrl.aluOp = OP_SLL;
                        ctrl.aluSrcShamt = 1'b1;
                    end
                    default: ctrl.regWr = 1'b0;
                endcase
            end
            6'h09, 6'h0f, 6'h0d, 6'h23: begin
                ctrl.regWr = 1'b1;
                ctrl.dstSel = DST_RT;
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt = (opcode != 6'h0d);
                ctrl.aluOp = (opcode == 6'h0f) ? OP_LUI :
                             (opcode == 6'h0d) ? OP_OR : OP_ADDU;
                ctrl.memRd = (opcode == 6'h23);
                ctrl.wbSel = (opcode == 6'h23) ? WB_MEM : WB_ALU;
            end
            6'h2b: begin
                ctrl.memWr = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt = 1'b1;
            end
            6'h04, 6'h05: begin
                // compare by subtraction in execute.
                ctrl.branch = 1'b1;
                ctrl.branchNe = (opcode == 6'h05);
                ctrl.signExt = 1'b1;
                ctrl.aluOp = OP_SUBU;
            end
            6'h02, 6'h03: begin
                ctrl.jump = 1'b1;
                ctrl.link = (opcode == 6'h03);
                ctrl.regWr = (opcode == 6'h03);
                ctrl.wbSel = (opcode == 6'h03) ? WB_LINK : WB_ALU;
                ctrl.dstSel = DST_RA;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- regFile.sv
// r0 is hardwired to zero; a same-cycle write is visible on both read ports.
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
    input logic sysclk,
    input logic rstN,
    input regAddrT rdAddrA,
    input regAddrT rdAddrB,
    input regAddrT wrAddr,
    input wordT wrData,
    input logic wrEn,
    output wordT rdDataA,
    output wordT rdDataB
);

    wordT regs [32];

    function automatic wordT readPort(regAddrT addr, logic we, regAddrT wa, wordT wd,
                                      wordT stored);
        if (addr == '0) begin
            return '0;
        end
        if (we && addr == wa) begin
            return wd;
        end
        return stored;
    endfunction

    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb begin
        rdDataA = readPort(rdAddrA, wrEn, wrAddr, wrData, regs[rdAddrA]);
        rdDataB = readPort(rdAddrB, wrEn, wrAddr, wrData, regs[rdAddrB]);
    end

endmodule

//--- aluUnit.sv
// slt is signed; sll takes its shift amount from a[4:0].
`timescale 1ns/1ns

module aluUnit import cpuPkg::*; (
    input wordT a,
    input wordT b,
    input aluOpT op,
    output wordT result,
    output logic zero
);

    always_comb begin
        case (op)
            OP_ADDU: result = a + b;
            OP_SUBU: result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            OP_SLL:  result = b << a[4:0];
            OP_LUI:  result = {b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    // used by beq and bne.
    assign zero = (result == '0);

endmodule

//--- hazardUnit.sv
// forwarding targets decode; a load in execute costs one stall, branches win over everything.
`timescale 1ns/1ns

module hazardUnit import cpuPkg::*; (
    input regAddrT rs,
    input regAddrT rt,
    input ctrlT idCtrl,
    input regAddrT exDst,
    input ctrlT exCtrl,
    input regAddrT memDst,
    input ctrlT memCtrl,
    input logic branchTaken,
    output fwdSelT fwdA,
    output fwdSelT fwdB,
    output logic stall,
    output logic flushIfId,
    output logic flushIdEx
);

    function automatic fwdSelT pickSource(regAddrT src, regAddrT eDst, logic eWr,
                                          regAddrT mDst, logic mWr);
        // youngest writer first.
        if (eWr && eDst != '0 && eDst == src) begin
            return FWD_EXMEM;
        end
        if (mWr && mDst != '0 && mDst == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    logic loadUse;

    assign fwdA = pickSource(rs, exDst, exCtrl.regWr, memDst, memCtrl.regWr);
    assign fwdB = pickSource(rt, exDst, exCtrl.regWr, memDst, memCtrl.regWr);

    assign loadUse = exCtrl.memRd && exDst != '0 && (exDst == rs || exDst == rt);

    // jumps read no registers, so they never wait on a load.
    assign stall = loadUse && !idCtrl.jump && !branchTaken;
    assign flushIfId = branchTaken || idCtrl.jump;
    assign flushIdEx = branchTaken || stall;

endmodule

//--- dataMemIo.sv
// word access only; loads never see the LED or digit registers, they read RAM.
`timescale 1ns/1ns

module dataMemIo import cpuPkg::*; #(
    parameter int DMEM_AW = 8
) (
    input logic sysclk,
    input logic rstN,
    input wordT addr,
    input wordT wrData,
    input logic memRd,
    input logic memWr,
    output wordT rdData,
    output logic [7:0] leds,
    output logic [15:0] digits
);

    wordT ram [2**DMEM_AW];
    logic [DMEM_AW-1:0] index;
    logic isLed;
    logic isDigit;

    assign index = addr[DMEM_AW+1:2];
    assign isLed = (addr == LED_ADDR);
    assign isDigit = (addr == DIGIT_ADDR);

    always_ff @(posedge sysclk) begin
        if (memWr && !isLed && !isDigit) begin
            ram[index] <= wrData;
        end
    end

    // mmio registers.
    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            leds <= '0;
            digits <= '0;
        end else if (memWr) begin
            if (isLed) begin
                leds <= wrData[7:0];
            end
            if (isDigit) begin
                digits <= wrData[15:0];
            end
        end
    end

    assign rdData = memRd ? ram[index] : '0;

endmodule

//--- displayScan.sv
// active-low anodes and segments, dp always off; each digit is lit 2**SCAN_DIV_LOG cycles.
`timescale 1ns/1ns

module displayScan #(
    parameter int SCAN_DIV_LOG = 16
) (
    input logic sysclk,
    input logic rstN,
    input logic [15:0] digits,
    output logic [3:0] an,
    output logic [7:0] seg
);

    logic [SCAN_DIV_LOG+1:0] cnt;
    logic [SCAN_DIV_LOG+1:0] cntNext;
    logic [1:0] sel;

    function automatic logic [7:0] hexSeg(logic [3:0] nib);
        case (nib)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    // select from the next count so the registered outputs line up with cnt.
    assign cntNext = cnt + 1'b1;
    assign sel = cntNext[SCAN_DIV_LOG+1 -: 2];

    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            cnt <= '0;
            an <= 4'b1110;
            seg <= 8'hC0;
        end else begin
            cnt <= cntNext;
            an <= ~(4'b0001 << sel);
            seg <= hexSeg(digits[sel*4 +: 4]);
        end
    end

endmodule

//--- pipelineCpu.sv
// five stages, no delay slots; hold run low while loading imem, pc restarts at 0.
`timescale 1ns/1ns

module pipelineCpu import cpuPkg::*; #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8,
    parameter int SCAN_DIV_LOG = 16
) (
    input logic sysclk,
    input logic rstN,
    input logic run,
    input logic imemWe,
    input logic [IMEM_AW-1:0] imemAddr,
    input wordT imemData,
    output logic [7:0] leds,
    output logic [3:0] an,
    output logic [7:0] seg
);

    wordT pc, pcPlus4, fetchInstr;
    ifIdT ifId;
    idExT idEx;
    exMemT exMem;
    memWbT memWb;

    ctrlT decCtrl, idCtrl, dstCtrl;
    regAddrT rs, rt, rd, idDst;
    wordT rfA, rfB, opA, opB, idImm, jTarget;
    fwdSelT fwdA, fwdB;
    logic stall, flushIfId, flushIdEx;

    wordT aluA, aluB, aluResult, exResult, brTarget;
    logic aluZero, branchTaken;

    wordT memRdData, memWbVal, wbData;
    logic [15:0] digits;

    function automatic wordT wbMux(wbSelT sel, wordT result, wordT memData);
        // link values are already folded into result in execute.
        return (sel == WB_MEM) ? memData : result;
    endfunction

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT exVal, wordT memVal);
        case (sel)
            FWD_EXMEM: return exVal;
            FWD_MEMWB: return memVal;
            default: return regVal;
        endcase
    endfunction

    // ******************************
    // fetch
    // ******************************
    assign pcPlus4 = pc + 32'd4;

    instMem #(.IMEM_AW(IMEM_AW)) uInstMem (
        .sysclk(sysclk), .we(imemWe), .wrAddr(imemAddr), .wrData(imemData),
        .rdAddr(pc[IMEM_AW+1:2]), .rdData(fetchInstr)
    );

    always_ff @(posedge sysclk) begin
        if (!rstN || !run) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= brTarget;
        end else if (idCtrl.jump) begin
            pc <= jTarget;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rstN || !run || flushIfId) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId <= '{valid: 1'b1, pcPlus4: pcPlus4, instr: fetchInstr};
        end
    end

    // ******************************
    // decode
    // ******************************
    assign rs = ifId.instr[25:21];
    assign rt = ifId.instr[20:16];
    assign rd = ifId.instr[15:11];

    controlDecoder uDecoder (.instr(ifId.instr), .ctrl(decCtrl));
    assign idCtrl = ifId.valid ? decCtrl : '0;

    regFile uRegFile (
        .sysclk(sysclk), .rstN(rstN), .rdAddrA(rs), .rdAddrB(rt),
        .wrAddr(memWb.dst), .wrData(wbData), .wrEn(memWb.ctrl.regWr),
        .rdDataA(rfA), .rdDataB(rfB)
    );

    hazardUnit uHazard (
        .rs(rs), .rt(rt), .idCtrl(idCtrl),
        .exDst(idEx.dst), .exCtrl(idEx.ctrl),
        .memDst(exMem.dst), .memCtrl(exMem.ctrl),
        .branchTaken(branchTaken), .fwdA(fwdA), .fwdB(fwdB),
        .stall(stall), .flushIfId(flushIfId), .flushIdEx(flushIdEx)
    );

    assign opA = fwdMux(fwdA, rfA, exResult, memWbVal);
    assign opB = fwdMux(fwdB, rfB, exResult, memWbVal);

    assign idImm = idCtrl.signExt ? {{16{ifId.instr[15]}}, ifId.instr[15:0]}
                                  : {16'b0, ifId.instr[15:0]};
    assign jTarget = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};
    assign idDst = (idCtrl.dstSel == DST_RA) ? 5'd31 :
                   (idCtrl.dstSel == DST_RT) ? rt : rd;

    // writes to r0 are dropped here, so later stages never carry them.
    always_comb begin
        dstCtrl = idCtrl;
        dstCtrl.regWr = idCtrl.regWr && (idDst != '0);
    end

    always_ff @(posedge sysclk) begin
        if (!rstN || flushIdEx) begin
            idEx <= '0;
        end else begin
            idEx <= '{ctrl: dstCtrl, pcPlus4: ifId.pcPlus4, rsVal: opA, rtVal: opB,
                      imm: idImm, dst: idDst};
        end
    end

    // ******************************
    // execute
    // ******************************
    assign aluA = idEx.ctrl.aluSrcShamt ? {27'b0, idEx.imm[10:6]} : idEx.rsVal;
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.rtVal;

    aluUnit uAlu (.a(aluA), .b(aluB), .op(idEx.ctrl.aluOp), .result(aluResult), .zero(aluZero));

    assign exResult = idEx.ctrl.link ? idEx.pcPlus4 : aluResult;
    assign branchTaken = idEx.ctrl.branch && (aluZero ^ idEx.ctrl.branchNe);
    assign brTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem <= '{ctrl: idEx.ctrl, result: exResult, storeData: idEx.rtVal,
                       dst: idEx.dst};
        end
    end

    // ******************************
    // memory and writeback
    // ******************************
    dataMemIo #(.DMEM_AW(DMEM_AW)) uDataMem (
        .sysclk(sysclk), .rstN(rstN), .addr(exMem.result), .wrData(exMem.storeData),
        .memRd(exMem.ctrl.memRd), .memWr(exMem.ctrl.memWr), .rdData(memRdData),
        .leds(leds), .digits(digits)
    );

    assign memWbVal = wbMux(exMem.ctrl.wbSel, exMem.result, memRdData);

    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb <= '{ctrl: exMem.ctrl, dst: exMem.dst, result: exMem.result,
                       memData: memRdData};
        end
    end

    assign wbData = wbMux(memWb.ctrl.wbSel, memWb.result, memWb.memData);

    displayScan #(.SCAN_DIV_LOG(SCAN_DIV_LOG)) uScan (
        .sysclk(sysclk), .rstN(rstN), .digits(digits), .an(an), .seg(seg)
    );

endmodule

//--- pipelineCpu_chk.sv
// bound into pipelineCpu; relies on its ifId, memWb, stall and branchTaken names, idle in reset.
`timescale 1ns/1ns

module pipelineCpuChk import cpuPkg::*; (
    input logic sysclk,
    input logic rstN,
    input logic run,
    input ifIdT ifId,
    input memWbT memWb,
    input logic stall,
    input logic branchTaken,
    input logic [3:0] an
);

    // r0 writes are dropped in decode.
    noZeroWrite: assert property (@(posedge sysclk) disable iff (!rstN)
        memWb.ctrl.regWr && !memWb.ctrl.link |-> memWb.dst != '0)
        else $error("register write to r0 reached writeback");

    branchFlush: assert property (@(posedge sysclk) disable iff (!rstN)
        $past(branchTaken) |-> !ifId.valid)
        else $error("ifId kept an instruction after a taken branch");

    stallHold: assert property (@(posedge sysclk) disable iff (!rstN)
        $past(stall) && $past(run) |-> ifId == $past(ifId))
        else $error("ifId changed during a stall");

    anOneHot: assert property (@(posedge sysclk) disable iff (!rstN)
        $onehot(~an))
        else $error("anode select is not one-hot low");

endmodule

//--- pipelineCpuTb.sv
// needs cpuPatterns.txt in the run directory; SCAN_DIV_LOG is 3, so each digit stays lit 8 cycles.
`timescale 1ns/1ns

module pipelineCpuTb import cpuPkg::*; ();

    localparam int IMEM_AW = 8;
    localparam int SCAN_DIV_LOG = 3;
    localparam int DIGIT_CYCLES = 1 << SCAN_DIV_LOG;
    localparam int SCAN_PERIOD = 4 * DIGIT_CYCLES;
    localparam int RESET_CYCLES = 5;
    localparam int PAT_DEPTH = 64;

    // standard hex digits, active low, dp off.
    localparam logic [7:0] SEG_TABLE [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic sysclk;
    logic rstN;
    logic run;
    logic imemWe;
    logic [IMEM_AW-1:0] imemAddr;
    wordT imemData;
    logic [7:0] leds;
    logic [3:0] an;
    logic [7:0] seg;

    wordT patterns [PAT_DEPTH];
    int progLen;
    int ledCount;
    int budget;
    wordT digitVal;
    int runCycles = 0;
    int ledIdx = 0;
    logic [7:0] lastLeds = '0;

    pipelineCpu #(.IMEM_AW(IMEM_AW), .SCAN_DIV_LOG(SCAN_DIV_LOG)) dut_i (
        .sysclk(sysclk), .rstN(rstN), .run(run), .imemWe(imemWe),
        .imemAddr(imemAddr), .imemData(imemData), .leds(leds), .an(an), .seg(seg)
    );

    bind pipelineCpu pipelineCpuChk chkI (
        .sysclk(sysclk), .rstN(rstN), .run(run), .ifId(ifId), .memWb(memWb),
        .stall(stall), .branchTaken(branchTaken), .an(an)
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;
    end

    task automatic stopRun();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input wordT got, input wordT exp);
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        stopRun();
    endtask

    task automatic reportProblem(input string what);
        $display("%s", what);
        stopRun();
    endtask

    function automatic logic [7:0] expectedLed(int i);
        return patterns[progLen + 2 + i][7:0];
    endfunction

    // ******************************
    // timeout and LED monitor
    // ******************************
    // one scan period to align, one to walk the digits, one spare.
    always @(posedge sysclk) begin
        if (run) begin
            runCycles <= runCycles + 1;
            if (runCycles >= budget + 3 * SCAN_PERIOD) begin
                reportProblem("simulation timed out before all checks were done");
            end
        end
    end

    always @(negedge sysclk) begin
        if (run && leds != lastLeds) begin
            assert (ledIdx < ledCount)
                else reportProblem("leds changed again after the last expected value");
            assert (leds == expectedLed(ledIdx))
                else reportMismatch("leds", leds, expectedLed(ledIdx));
            if (ledIdx == ledCount - 1) begin
                assert (runCycles <= budget)
                    else reportProblem("last LED value arrived after the cycle budget");
            end
            lastLeds = leds;
            ledIdx = ledIdx + 1;
        end
    end

    // ******************************
    // stimulus and display checks
    // ******************************
    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge sysclk);
            imemWe <= 1'b1;
            imemAddr <= IMEM_AW'(i);
            imemData <= patterns[i + 1];
        end
        @(posedge sysclk);
        imemWe <= 1'b0;
        run <= 1'b1;
    endtask

    task automatic checkDisplayScan();
        logic [3:0] prevAn;
        logic [3:0] expAn;
        logic [3:0] nib;
        prevAn = an;
        @(negedge sysclk);
        // wait for the start of digit 0.
        while (an != 4'b1110 || prevAn == 4'b1110) begin
            prevAn = an;
            @(negedge sysclk);
        end
        for (int d = 0; d < 4; d++) begin
            expAn = ~(4'b0001 << d);
            nib = digitVal[d*4 +: 4];
            for (int c = 0; c < DIGIT_CYCLES; c++) begin
                assert (an == expAn) else reportMismatch("an", an, expAn);
                assert (seg == SEG_TABLE[nib]) else reportMismatch("seg", seg, SEG_TABLE[nib]);
                @(negedge sysclk);
            end
        end
        assert (an == 4'b1110) else reportMismatch("an", an, 4'b1110);
    endtask

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        $readmemh("cpuPatterns.txt", patterns);
        progLen = patterns[0];
        assert (progLen > 0 && progLen <= 2**IMEM_AW && progLen + 5 < PAT_DEPTH)
            else reportProblem("program length in the patterns file is out of range");
        ledCount = patterns[progLen + 1];
        assert (ledCount > 0 && progLen + ledCount + 4 <= PAT_DEPTH)
            else reportProblem("LED count in the patterns file is out of range");
        digitVal = patterns[progLen + 2 + ledCount];
        budget = patterns[progLen + 3 + ledCount];

        repeat (RESET_CYCLES) @(posedge sysclk);
        rstN <= 1'b1;
        @(negedge sysclk);
        assert (leds == 8'h00) else reportMismatch("leds", leds, 8'h00);
        assert (an == 4'b1110) else reportMismatch("an", an, 4'b1110);
        assert (seg == 8'hC0) else reportMismatch("seg", seg, 8'hC0);

        loadProgram();
        wait (ledIdx == ledCount);
        checkDisplayScan();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- cpuPatterns.txt
// layout: program length, program words, LED count, LED values, final digit value, cycle budget
// all values hex; comments give the instruction behind each program word
21                          // 33 program words
3C014000 24020005 24030003  // lui r1,0x4000 | addiu r2,r0,5 | addiu r3,r0,3
00432021 AC240000           // addu r4,r2,r3 | sw r4,0(r1) led 08
00043823 00E3402A 000841C0  // subu r7,r0,r4 | slt r8,r7,r3 | sll r8,r8,7
00434824 01284825 AC290000  // and r9,r2,r3 | or r9,r9,r8 | sw r9,0(r1) led 81
AC090008 8C0A0008 254AFFC0  // sw r9,8(r0) | lw r10,8(r0) | addiu r10,r10,-64 load use
AC2A0000                    // sw r10,0(r1) led 41
10420002 AC200000 AC230000  // beq r2,r2,+2 taken | two flushed stores
14420001 340B005A AC2B0000  // bne r2,r2,+1 not taken | ori r11,r0,0x5a | sw r11 led 5a
0C000017 AC220000 AC3F0000  // jal 23 | flushed store | sw r31,0(r1) led 58
0800001A AC200000           // j 26 | flushed store
340CA3C7 AC2C0004           // ori r12,r0,0xa3c7 | sw r12,4(r1) digits
240D003C AC2D0000           // addiu r13,r0,0x3c | sw r13,0(r1) led 3c
1000FFFF 00000000 00000000  // beq r0,r0,-1 spin | padding nops
6                           // LED count
08 81 41 5A 58 3C           // expected LED sequence
A3C7                        // final digit value
30                          // cycle budget, 48 cycles after run rises

//--- vlog.f
cpuPkg.sv
instMem.sv
controlDecoder.sv
regFile.sv
aluUnit.sv
hazardUnit.sv
dataMemIo.sv
displayScan.sv
pipelineCpu.sv
pipelineCpu_chk.sv
pipelineCpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module pipelineCpuTb -f vlog.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
# an assertion stop ends the run without the pass line.
grep -q "NO ERRORS" sim.log
